/* rtl/acq_pkg.sv */
// sizes and register map for the acquisition subsystem; level codes and results share RES_W.

package acq_pkg;

  ////////////////////////////////////////
  // datapath sizes.
  ////////////////////////////////////////

  // number of converter channels in the generate loop.
  localparam int NUM_CH = 4;
  // result and level code width.
  localparam int RES_W = 16;
  // precharge pause counter width.
  localparam int CNT_W = 24;
  // fixed run-up length of every conversion.
  localparam int RUNUP_CYCLES = 8;
  // frame sequence number width, wraps silently.
  localparam int SEQ_W = 16;

  // frame buffer, depth must be a power of two.
  localparam int FIFO_DEPTH = 8;
  localparam int FIFO_AW = 3;

  ////////////////////////////////////////
  // host bus and register map.
  ////////////////////////////////////////

  localparam int WB_AW = 4;
  localparam int WB_DW = 32;

  // word addresses.
  localparam logic [WB_AW-1:0] REG_CTRL      = 4'd0;
  localparam logic [WB_AW-1:0] REG_PRECHARGE = 4'd1;
  localparam logic [WB_AW-1:0] REG_STATUS    = 4'd2;
  localparam logic [WB_AW-1:0] REG_FRAME     = 4'd3;
  // results of channel n sit at REG_RESULT0 + n.
  localparam logic [WB_AW-1:0] REG_RESULT0   = 4'd4;

  ////////////////////////////////////////
  // sequencer states.
  ////////////////////////////////////////

  typedef enum logic [2:0] {
    SEQ_PARK,
    SEQ_PRECHARGE,
    SEQ_WAIT_PRECHARGE,
    SEQ_WAIT_ACK,
    SEQ_WAIT_DONE
  } seq_state_t;

endpackage

/* rtl/slope_adc.sv */
// behavioural counting converter, not analog; result equals the sampled level code.
`timescale 1ns/1ns

module slope_adc
  import acq_pkg::*;
(
  input  logic             clk,
  input  logic             rst,
  input  logic             start,
  input  logic [RES_W-1:0] level,
  output logic             valid,
  output logic [RES_W-1:0] result
);

  typedef enum logic [1:0] {
    ADC_IDLE,
    ADC_RUNUP,
    ADC_RUNDOWN
  } adc_phase_t;

  adc_phase_t       phase;
  // shared phase counter.
  logic [RES_W-1:0] cnt;
  // level held for the whole conversion.
  logic [RES_W-1:0] level_q;

  always_ff @(posedge clk)
  begin
    if (phase == ADC_IDLE && start)
      level_q <= level;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      phase  <= ADC_IDLE;
      valid  <= 1'b1;
      result <= '0;
      cnt    <= '0;
    end
    else
    begin
      case (phase)
        // dropping valid is the trigger ack.
        ADC_IDLE:
        begin
          if (start)
          begin
            valid <= 1'b0;
            cnt   <= '0;
            phase <= ADC_RUNUP;
          end
        end

        // fixed length integrate.
        ADC_RUNUP:
        begin
          if (cnt == RES_W'(RUNUP_CYCLES - 1))
          begin
            cnt   <= '0;
            phase <= ADC_RUNDOWN;
          end
          else
            cnt <= cnt + 1'b1;
        end

        // counts up to the held level.
        ADC_RUNDOWN:
        begin
          if (cnt == level_q)
          begin
            result <= level_q;
            valid  <= 1'b1;
            phase  <= ADC_IDLE;
          end
          else
            cnt <= cnt + 1'b1;
        end

        default:
          phase <= ADC_IDLE;
      endcase
    end
  end

  // valid is held low across the whole conversion.
  busy_not_valid : assert property (@(posedge clk) disable iff (rst)
    (phase != ADC_IDLE) |-> !valid);

endmodule

/* rtl/acq_sequencer.sv */
// comes out of reset parked; run is sampled raw, so the host must hold it for two clocks.
`timescale 1ns/1ns

module acq_sequencer
  import acq_pkg::*;
(
  input  logic             clk,
  input  logic             rst,
  input  logic             run,
  input  logic [CNT_W-1:0] precharge_cycles,
  input  logic             measure_valid,
  output logic             measure_trig,
  output logic             led,
  output seq_state_t       state
);

  // old and new sample of run.
  logic [1:0]       run_edge;
  // precharge pause down counter.
  logic [CNT_W-1:0] count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state        <= SEQ_PARK;
      measure_trig <= 1'b0;
      led          <= 1'b0;
      run_edge     <= 2'b00;
      count        <= '0;
    end
    else
    begin
      run_edge <= {run_edge[0], run};

      case (state)
        ////////////////////////////////////////
        // one cycle, loads the pause and blinks.
        ////////////////////////////////////////
        SEQ_PRECHARGE:
        begin
          state <= SEQ_WAIT_PRECHARGE;
          count <= precharge_cycles;
          // alternate samples keep the blink visible at fast rates.
          led   <= ~led;
        end

        // pause lasts precharge_cycles+1 cycles.
        SEQ_WAIT_PRECHARGE:
        begin
          if (count == '0)
          begin
            measure_trig <= 1'b1;
            state        <= SEQ_WAIT_ACK;
          end
          else
          begin
            count <= count - 1'b1;
          end
        end

        ////////////////////////////////////////
        // trigger handshake with the channels.
        ////////////////////////////////////////
        // channels ack by dropping valid.
        SEQ_WAIT_ACK:
        begin
          if (!measure_valid)
          begin
            measure_trig <= 1'b0;
            state        <= SEQ_WAIT_DONE;
          end
        end

        // rising valid marks the end of conversion.
        SEQ_WAIT_DONE:
        begin
          if (measure_valid)
            state <= SEQ_PRECHARGE;
        end

        // parked, nothing to do until run rises.
        SEQ_PARK:
          measure_trig <= 1'b0;

        default:
          state <= SEQ_PARK;
      endcase

      // start and park are edge driven and win over any state.
      if (run_edge == 2'b01)
      begin
        state        <= SEQ_PRECHARGE;
        measure_trig <= 1'b0;
      end
      else if (run_edge == 2'b10)
      begin
        state        <= SEQ_PARK;
        measure_trig <= 1'b0;
      end
    end
  end

  // a park entered from any active state leaves the trigger low.
  park_drops_trig : assert property (@(posedge clk) disable iff (rst)
    (state == SEQ_PARK) && ($past(state) != SEQ_PARK) |=> !measure_trig);

endmodule

/* rtl/result_collector.sv */
// frames arriving while the buffer is full are dropped but still use a sequence number.
`timescale 1ns/1ns

module result_collector
  import acq_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst,
  input  logic [NUM_CH-1:0]       ch_valid,
  input  logic [NUM_CH*RES_W-1:0] ch_results,
  input  logic                    pop,
  input  logic                    clr_ovf,
  output logic                    measure_valid,
  output logic                    avail,
  output logic [FIFO_AW:0]        fill_count,
  output logic                    overflow,
  output logic [SEQ_W-1:0]        head_seq,
  output logic [NUM_CH*RES_W-1:0] head_results
);

  logic                    all_valid;
  logic                    push;
  logic                    push_ok;
  logic                    pop_ok;
  logic                    full;
  logic [SEQ_W-1:0]        seq_cnt;
  logic [FIFO_AW-1:0]      wr_ptr;
  logic [FIFO_AW-1:0]      rd_ptr;
  logic [SEQ_W-1:0]        seq_mem [FIFO_DEPTH];
  logic [NUM_CH*RES_W-1:0] res_mem [FIFO_DEPTH];

  ////////////////////////////////////////
  // completion detect.
  ////////////////////////////////////////

  assign all_valid = &ch_valid;
  // the last channel to finish completes the frame.
  assign push      = all_valid && !measure_valid;

  assign full    = (fill_count == (FIFO_AW + 1)'(FIFO_DEPTH));
  assign avail   = (fill_count != '0);
  assign push_ok = push && !full;
  // pops on an empty buffer fall away here.
  assign pop_ok  = pop && avail;

  ////////////////////////////////////////
  // buffer control.
  ////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      // channels come out of reset valid, so no spurious frame.
      measure_valid <= 1'b1;
      seq_cnt       <= '0;
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      fill_count    <= '0;
      overflow      <= 1'b0;
    end
    else
    begin
      measure_valid <= all_valid;
      if (push)
        seq_cnt <= seq_cnt + 1'b1;
      if (push_ok)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop_ok)
        rd_ptr <= rd_ptr + 1'b1;
      if (push_ok && !pop_ok)
        fill_count <= fill_count + 1'b1;
      else if (pop_ok && !push_ok)
        fill_count <= fill_count - 1'b1;
      // a new drop beats a clear in the same cycle.
      if (push && full)
        overflow <= 1'b1;
      else if (clr_ovf)
        overflow <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (push_ok)
    begin
      seq_mem[wr_ptr] <= seq_cnt;
      res_mem[wr_ptr] <= ch_results;
    end
  end

  // head reads as zero when nothing is queued.
  assign head_seq     = avail ? seq_mem[rd_ptr] : '0;
  assign head_results = avail ? res_mem[rd_ptr] : '0;

  no_write_when_full : assert property (@(posedge clk) disable iff (rst)
    full |=> $stable(wr_ptr));

  // a frame landing in the same cycle may still raise the fill count.
  empty_pop_ignored : assert property (@(posedge clk) disable iff (rst)
    (pop && !avail && !push) |=> $stable(rd_ptr) && $stable(fill_count));

endmodule

/* rtl/acq_regs.sv */
// wishbone classic slave, one wait state per access; no burst or error support.
`timescale 1ns/1ns

module acq_regs
  import acq_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    wb_cyc,
  input  logic                    wb_stb,
  input  logic                    wb_we,
  input  logic [WB_AW-1:0]        wb_adr,
  input  logic [WB_DW-1:0]        wb_dat_w,
  output logic [WB_DW-1:0]        wb_dat_r,
  output logic                    wb_ack,
  output logic                    run,
  output logic [CNT_W-1:0]        precharge_cycles,
  output logic                    pop,
  output logic                    clr_ovf,
  input  logic                    avail,
  input  logic [FIFO_AW:0]        fill_count,
  input  logic                    overflow,
  input  logic [SEQ_W-1:0]        head_seq,
  input  logic [NUM_CH*RES_W-1:0] head_results
);

  logic             access;
  logic             wr_en;
  logic [WB_DW-1:0] rd_data;

  // a new access is seen only while ack is low.
  assign access = wb_cyc && wb_stb && !wb_ack;
  assign wr_en  = access && wb_we;

  ////////////////////////////////////////
  // write side.
  ////////////////////////////////////////

  // pulses land on the ack edge, so the next access sees the new head.
  assign pop     = wr_en && (wb_adr == REG_FRAME);
  // any value written to status clears overflow.
  assign clr_ovf = wr_en && (wb_adr == REG_STATUS);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wb_ack           <= 1'b0;
      run              <= 1'b0;
      precharge_cycles <= '0;
    end
    else
    begin
      wb_ack <= access;
      if (wr_en)
      begin
        case (wb_adr)
          REG_CTRL:
            run <= wb_dat_w[0];
          REG_PRECHARGE:
            precharge_cycles <= wb_dat_w[CNT_W-1:0];
          default:
            ;
        endcase
      end
    end
  end

  ////////////////////////////////////////
  // read side.
  ////////////////////////////////////////

  always_comb
  begin
    rd_data = '0;
    case (wb_adr)
      REG_CTRL:
        rd_data[0] = run;
      REG_PRECHARGE:
        rd_data[CNT_W-1:0] = precharge_cycles;
      REG_STATUS:
      begin
        rd_data[0]                 = avail;
        rd_data[1]                 = overflow;
        rd_data[8 +: FIFO_AW + 1] = fill_count;
      end
      REG_FRAME:
        rd_data[SEQ_W-1:0] = head_seq;
      default:
      begin
        // result window, one word per channel.
        for (int ch = 0; ch < NUM_CH; ch++)
        begin
          if (wb_adr == REG_RESULT0 + WB_AW'(ch))
            rd_data[RES_W-1:0] = head_results[ch*RES_W +: RES_W];
        end
      end
    endcase
  end

  // read data is captured on the ack edge and held while ack is high.
  always_ff @(posedge clk)
  begin
    if (access)
      wb_dat_r <= rd_data;
  end

  single_cycle_ack : assert property (@(posedge clk) disable iff (rst)
    wb_ack |=> !wb_ack);

endmodule

/* rtl/acq_top.sv */
// all channels share one trigger; level codes must stay stable while a conversion runs.
`timescale 1ns/1ns

module acq_top
  import acq_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    wb_cyc,
  input  logic                    wb_stb,
  input  logic                    wb_we,
  input  logic [WB_AW-1:0]        wb_adr,
  input  logic [WB_DW-1:0]        wb_dat_w,
  output logic [WB_DW-1:0]        wb_dat_r,
  output logic                    wb_ack,
  input  logic [NUM_CH*RES_W-1:0] levels,
  output logic                    led,
  output logic [1:0]              monitor
);

  logic                    run;
  logic [CNT_W-1:0]        precharge_cycles;
  logic                    pop;
  logic                    clr_ovf;
  logic                    measure_trig;
  logic                    measure_valid;
  seq_state_t              seq_state;
  logic [NUM_CH-1:0]       ch_valid;
  logic [NUM_CH*RES_W-1:0] ch_results;
  logic                    avail;
  logic [FIFO_AW:0]        fill_count;
  logic                    overflow;
  logic [SEQ_W-1:0]        head_seq;
  logic [NUM_CH*RES_W-1:0] head_results;

  acq_regs u_regs (
    .clk(clk), .rst(rst), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
    .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
    .run(run), .precharge_cycles(precharge_cycles), .pop(pop), .clr_ovf(clr_ovf),
    .avail(avail), .fill_count(fill_count), .overflow(overflow),
    .head_seq(head_seq), .head_results(head_results)
  );

  acq_sequencer u_seq (
    .clk(clk), .rst(rst), .run(run), .precharge_cycles(precharge_cycles),
    .measure_valid(measure_valid), .measure_trig(measure_trig), .led(led),
    .state(seq_state)
  );

  ////////////////////////////////////////
  // converter channels, channel 0 low.
  ////////////////////////////////////////
  for (genvar i = 0; i < NUM_CH; i++)
  begin : g_ch
    slope_adc u_adc (
      .clk(clk), .rst(rst), .start(measure_trig),
      .level(levels[i*RES_W +: RES_W]),
      .valid(ch_valid[i]), .result(ch_results[i*RES_W +: RES_W])
    );
  end

  result_collector u_coll (
    .clk(clk), .rst(rst), .ch_valid(ch_valid), .ch_results(ch_results),
    .pop(pop), .clr_ovf(clr_ovf), .measure_valid(measure_valid), .avail(avail),
    .fill_count(fill_count), .overflow(overflow), .head_seq(head_seq),
    .head_results(head_results)
  );

  // scope pins, trigger and joined valid.
  assign monitor = {measure_valid, measure_trig};

  // the trigger is only ever up while the sequencer waits for the ack.
  trig_only_in_ack : assert property (@(posedge clk) disable iff (rst)
    measure_trig |-> (seq_state == SEQ_WAIT_ACK));

endmodule

/* verification/tb_clock_gen.sv */
// free running 10 ns clock; rst is released on a falling edge after two rising edges.
`timescale 1ns/1ns

module tb_clock_gen (
  output logic clk,
  output logic rst
);

  // 100 MHz clock.
  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // reset covers two rising edges.
  initial
  begin
    rst = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

/* verification/tb_acq.sv */
// self-checking testbench; level codes are 8-bit and change only while parked and idle.
`timescale 1ns/1ns

module tb_acq
  import acq_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 20000;
  // longest conversion plus handshake margin.
  localparam int SETTLE_CYCLES  = 300;

  logic                    clk;
  logic                    rst;
  logic                    wb_cyc;
  logic                    wb_stb;
  logic                    wb_we;
  logic [WB_AW-1:0]        wb_adr;
  logic [WB_DW-1:0]        wb_dat_w;
  logic [WB_DW-1:0]        wb_dat_r;
  logic                    wb_ack;
  logic [NUM_CH*RES_W-1:0] levels;
  logic                    led;
  logic [1:0]              monitor;

  // reference model of the frame buffer.
  logic [SEQ_W-1:0]        exp_seq_q [$];
  logic [NUM_CH*RES_W-1:0] exp_res_q [$];
  logic [SEQ_W-1:0]        next_seq;
  logic [SEQ_W-1:0]        last_seq;
  logic                    exp_ovf;
  logic                    prev_valid;
  logic                    prev_led;
  logic                    led_toggled;
  int                      errors;
  int                      errors_at_test_start;
  int                      tests;
  int                      cycles;

  tb_clock_gen u_clk (
    .clk(clk),
    .rst(rst)
  );

  acq_top DUT (
    .clk(clk), .rst(rst), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
    .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
    .levels(levels), .led(led), .monitor(monitor)
  );

  ////////////////////////////////////////
  // model and watchdog.
  ////////////////////////////////////////

  // a rising joined valid is one completed frame.
  always @(negedge clk)
  begin
    if (rst)
    begin
      prev_valid = 1'b1;
      prev_led   = 1'b0;
    end
    else
    begin
      if (monitor[1] && !prev_valid)
      begin
        // full buffer drops the frame but the number is gone.
        if (exp_seq_q.size() < FIFO_DEPTH)
        begin
          exp_seq_q.push_back(next_seq);
          exp_res_q.push_back(levels);
        end
        else
          exp_ovf = 1'b1;
        next_seq = next_seq + 1'b1;
      end
      if (led != prev_led)
        led_toggled = 1'b1;
      prev_valid = monitor[1];
      prev_led   = led;
    end
  end

  initial
  begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("STATUS: FAIL");
    $finish;
  end

  ////////////////////////////////////////
  // helpers.
  ////////////////////////////////////////

  task automatic report_mismatch(input string sig, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("FAIL %s expected %h actual %h", sig, exp, act);
    errors++;
  endtask

  // one classic cycle, entered and left on a falling edge.
  task automatic bus_access(input logic we, input logic [WB_AW-1:0] adr,
                            input logic [WB_DW-1:0] wdat, output logic [WB_DW-1:0] rdat);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdat;
    @(negedge clk);
    while (!wb_ack)
      @(negedge clk);
    rdat   = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    @(negedge clk);
    // a second ack cycle would count as a second access.
    if (wb_ack)
    begin
      $display("ack stayed high for more than one cycle at address %0d", adr);
      errors++;
    end
  endtask

  task automatic bus_write(input logic [WB_AW-1:0] adr, input logic [WB_DW-1:0] data);
    logic [WB_DW-1:0] discard;
    bus_access(1'b1, adr, data, discard);
  endtask

  task automatic bus_read(input logic [WB_AW-1:0] adr, output logic [WB_DW-1:0] data);
    bus_access(1'b0, adr, '0, data);
  endtask

  function automatic logic [31:0] model_status();
    logic [31:0] s;
    s        = '0;
    s[0]     = (exp_seq_q.size() != 0);
    s[1]     = exp_ovf;
    s[11:8]  = 4'(exp_seq_q.size());
    return s;
  endfunction

  task automatic pick_levels();
    for (int ch = 0; ch < NUM_CH; ch++)
      levels[ch*RES_W +: RES_W] = RES_W'($urandom % 256);
  endtask

  // clear run, then wait out any conversion in flight.
  task automatic park_and_settle();
    int trig_high;
    trig_high = 0;
    bus_write(REG_CTRL, 32'h0);
    // park lands two clocks after the run write.
    repeat (4) @(negedge clk);
    for (int i = 0; i < SETTLE_CYCLES; i++)
    begin
      @(negedge clk);
      if (monitor[0] !== 1'b0)
        trig_high++;
    end
    if (trig_high != 0)
    begin
      $display("trigger was high for %0d cycles while parked", trig_high);
      errors++;
    end
  endtask

  // pop every queued frame and compare it with the model.
  task automatic drain_frames();
    logic [WB_DW-1:0]        rd;
    logic [NUM_CH*RES_W-1:0] exp_res;
    while (exp_seq_q.size() != 0)
    begin
      bus_read(REG_FRAME, rd);
      if (rd !== {16'h0, exp_seq_q[0]})
        report_mismatch("FRAME", {16'h0, exp_seq_q[0]}, rd);
      exp_res = exp_res_q[0];
      for (int ch = 0; ch < NUM_CH; ch++)
      begin
        bus_read(REG_RESULT0 + WB_AW'(ch), rd);
        if (rd !== {16'h0, exp_res[ch*RES_W +: RES_W]})
          report_mismatch($sformatf("RESULT%0d", ch), {16'h0, exp_res[ch*RES_W +: RES_W]}, rd);
      end
      last_seq = exp_seq_q[0];
      bus_write(REG_FRAME, $urandom);
      void'(exp_seq_q.pop_front());
      void'(exp_res_q.pop_front());
      bus_read(REG_STATUS, rd);
      if (rd !== model_status())
        report_mismatch("STATUS", model_status(), rd);
    end
  endtask

  task automatic end_test(input string name);
    tests++;
    if (errors == errors_at_test_start)
      $display("test %0d %s: ok", tests, name);
    else
      $display("test %0d %s: %0d errors", tests, name, errors - errors_at_test_start);
    errors_at_test_start = errors;
  endtask

  ////////////////////////////////////////
  // test sequence.
  ////////////////////////////////////////

  initial
  begin
    logic [WB_DW-1:0] rd;
    logic [WB_DW-1:0] wdat;
    void'($urandom(32'h9d96a08e));
    wb_cyc      = 1'b0;
    wb_stb      = 1'b0;
    wb_we       = 1'b0;
    wb_adr      = '0;
    wb_dat_w    = '0;
    levels      = '0;
    next_seq    = '0;
    last_seq    = '0;
    exp_ovf     = 1'b0;
    led_toggled = 1'b0;
    errors      = 0;
    tests       = 0;
    errors_at_test_start = 0;
    @(negedge clk);
    while (rst)
      @(negedge clk);

    // reset values.
    if (led !== 1'b0)
      report_mismatch("led", 32'h0, {31'h0, led});
    if (monitor !== 2'b10)
      report_mismatch("monitor", 32'h2, {30'h0, monitor});
    bus_read(REG_STATUS, rd);
    if (rd !== 32'h0)
      report_mismatch("STATUS", 32'h0, rd);
    for (int a = 3; a < 8; a++)
    begin
      bus_read(WB_AW'(a), rd);
      if (rd !== 32'h0)
        report_mismatch($sformatf("reg%0d", a), 32'h0, rd);
    end
    bus_read(4'd8 + WB_AW'($urandom % 8), rd);
    if (rd !== 32'h0)
      report_mismatch("unmapped", 32'h0, rd);
    end_test("reset values");

    // register access while run stays low.
    wdat = $urandom;
    bus_write(REG_PRECHARGE, wdat);
    bus_read(REG_PRECHARGE, rd);
    if (rd !== {8'h0, wdat[23:0]})
      report_mismatch("PRECHARGE", {8'h0, wdat[23:0]}, rd);
    wdat = $urandom & ~32'h1;
    bus_write(REG_CTRL, wdat);
    bus_read(REG_CTRL, rd);
    if (rd !== 32'h0)
      report_mismatch("CTRL", 32'h0, rd);
    end_test("register access");

    // acquisition with one set of levels.
    pick_levels();
    bus_write(REG_PRECHARGE, 1 + ($urandom % 64));
    bus_write(REG_CTRL, 32'h1);
    bus_read(REG_CTRL, rd);
    if (rd !== 32'h1)
      report_mismatch("CTRL", 32'h1, rd);
    while (exp_seq_q.size() < 5)
      @(negedge clk);
    park_and_settle();
    drain_frames();
    end_test("acquisition");

    // park while running, then the fill count must hold.
    bus_write(REG_CTRL, 32'h1);
    while (exp_seq_q.size() == 0)
      @(negedge clk);
    park_and_settle();
    bus_read(REG_STATUS, wdat);
    park_and_settle();
    bus_read(REG_STATUS, rd);
    if (rd !== wdat)
      report_mismatch("STATUS", wdat, rd);
    if (rd !== model_status())
      report_mismatch("STATUS", model_status(), rd);
    if (!led_toggled)
    begin
      $display("led never toggled during acquisition");
      errors++;
    end
    drain_frames();
    end_test("park");

    // overflow with nobody reading.
    bus_write(REG_CTRL, 32'h1);
    rd = '0;
    while (rd[1] !== 1'b1)
      bus_read(REG_STATUS, rd);
    if (rd[11:8] !== 4'd8)
      report_mismatch("STATUS fill", 32'h8, {28'h0, rd[11:8]});
    park_and_settle();
    bus_read(REG_STATUS, rd);
    if (rd !== model_status())
      report_mismatch("STATUS", model_status(), rd);
    drain_frames();
    bus_write(REG_STATUS, $urandom);
    exp_ovf = 1'b0;
    bus_read(REG_STATUS, rd);
    if (rd !== 32'h0)
      report_mismatch("STATUS", 32'h0, rd);
    end_test("overflow");

    // restart with new levels after the dropped frames.
    pick_levels();
    bus_write(REG_PRECHARGE, 1 + ($urandom % 64));
    bus_write(REG_CTRL, 32'h1);
    while (exp_seq_q.size() < 3)
      @(negedge clk);
    park_and_settle();
    bus_read(REG_FRAME, rd);
    if (rd[SEQ_W-1:0] == SEQ_W'(last_seq + 1'b1))
    begin
      $display("sequence numbers after the overflow show no gap");
      errors++;
    end
    drain_frames();
    end_test("restart");

    $display("tests %0d, errors %0d", tests, errors);
    if (errors == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

/* acq_sub.f */
rtl/acq_pkg.sv
rtl/slope_adc.sv
rtl/acq_sequencer.sv
rtl/result_collector.sv
rtl/acq_regs.sv
rtl/acq_top.sv
verification/tb_clock_gen.sv
verification/tb_acq.sv
